//--- Makefile
# Verilator build for the BRAM batch engine

VERILATOR ?= verilator
TOP       ?= tb_bram_batch
FILELIST  ?= bram_batch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_EXE) 2>&1 | tee $(LOG)
	@grep -q -F -- '$(PASS_TEXT)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bram_batch.f
+incdir+include
src/bram_batch_pkg.sv
src/axil_cmd_regs.sv
src/batch_sequencer.sv
src/span_counter.sv
src/bank_array.sv
src/bram_batch_top.sv
sim/tb_bram_batch.sv

//--- include/bram_batch_cfg.svh
`ifndef BRAM_BATCH_CFG_SVH
`define BRAM_BATCH_CFG_SVH

// Bank geometry
`define BB_BANK_COUNT 4
`define BB_BANK_DEPTH 64

`define BB_DATA_WIDTH 32   // Stream word

// Control register byte offsets
`define BB_REG_CMD      8'h00
`define BB_REG_WR_BANKS 8'h04
`define BB_REG_WR_SPAN  8'h08
`define BB_REG_RD_BANKS 8'h0c
`define BB_REG_RD_SPAN  8'h10
`define BB_REG_STATUS   8'h14

`endif

//--- sim/tb_bram_batch.sv
`timescale 1ns/1ps
`include "bram_batch_cfg.svh"

module tb_bram_batch;
    import bram_batch_pkg::*;

    localparam int HS_TIMEOUT = 100;   // Cycles per handshake
    localparam int POLL_LIMIT = 400;   // STATUS reads per batch

    logic                      aclk;
    logic                      aresetn;
    axil_req_t                 axil_req;
    axil_rsp_t                 axil_rsp;
    stream_beat_t              in_beat;
    stream_beat_t              out_beat;

    logic [31:0]               lcg_state;
    logic [`BB_DATA_WIDTH-1:0] ref_mem [`BB_BANK_COUNT][`BB_BANK_DEPTH];
    logic [`BB_DATA_WIDTH-1:0] exp_q [$];
    int                        beats_seen;
    int                        beats_before;
    logic                      reads_open;   // A read batch may present beats
    logic [31:0]               rd_word;

    bram_batch_top uut (
        .aclk, .aresetn, .axil_req, .axil_rsp, .in_beat, .out_beat
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
            else fail_now($sformatf("mismatch at %0t: %s expected %h got %h",
                                    $time, name, exp, got));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ==============================
    // AXI4-Lite master
    // ==============================
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(negedge aclk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!axil_rsp.bvalid && n < HS_TIMEOUT);
        if (!axil_rsp.bvalid)
            fail_now("timeout waiting for bvalid on an AXI4-Lite write");
        check_eq("bresp", 32'h0, {30'd0, axil_rsp.bresp});
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        @(negedge aclk);
        axil_req.bready  = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(negedge aclk);
        check_eq("arready", 32'h1, {31'd0, axil_rsp.arready});
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!axil_rsp.rvalid && n < HS_TIMEOUT);
        if (!axil_rsp.rvalid)
            fail_now("timeout waiting for rvalid on an AXI4-Lite read");
        data = axil_rsp.rdata;
        check_eq("rresp", 32'h0, {30'd0, axil_rsp.rresp});
        check_eq("arready", 32'h0, {31'd0, axil_rsp.arready});
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        @(negedge aclk);
        axil_req.rready  = 1'b0;
    endtask

    // Bank range and span for one side
    task automatic program_side(input bit is_read, input int first, input int last,
                                input int start, input int count);
        logic [31:0] banks_word;
        logic [31:0] span_word;
        banks_word = {16'd0, 8'(last), 8'(first)};
        span_word  = {16'(count), 16'(start)};
        if (is_read) begin
            axil_write(`BB_REG_RD_BANKS, banks_word);
            axil_write(`BB_REG_RD_SPAN, span_word);
        end else begin
            axil_write(`BB_REG_WR_BANKS, banks_word);
            axil_write(`BB_REG_WR_SPAN, span_word);
        end
    endtask

    task automatic wait_idle(output logic [31:0] status);
        int polls;
        polls = 0;
        axil_read(`BB_REG_STATUS, status);
        while (status[0] && polls < POLL_LIMIT) begin
            axil_read(`BB_REG_STATUS, status);
            polls++;
        end
        if (status[0])
            fail_now("timeout waiting for busy to clear");
    endtask

    // ==============================
    // Stream side
    // ==============================
    task automatic feed_banks(input int first, input int last, input int start, input int count);
        int                        last_bank;
        int                        gap;
        logic [`BB_DATA_WIDTH-1:0] word;
        last_bank = (first > last) ? first : last;
        for (int b = first; b <= last_bank; b++) begin
            for (int i = 0; i < count; i++) begin
                gap = int'(lcg_next() >> 30);
                repeat (gap) begin
                    @(negedge aclk);
                    in_beat.valid = 1'b0;
                end
                word = lcg_next();
                @(negedge aclk);
                in_beat.valid = 1'b1;
                in_beat.data  = word;
                ref_mem[b % `BB_BANK_COUNT][(start + i) % `BB_BANK_DEPTH] = word;
            end
            @(negedge aclk);
            in_beat.valid = 1'b0;   // Counter reload between banks
        end
    endtask

    task automatic queue_reads(input int first, input int last, input int start, input int count);
        int last_bank;
        last_bank = (first > last) ? first : last;
        for (int b = first; b <= last_bank; b++) begin
            for (int i = 0; i < count; i++)
                exp_q.push_back(ref_mem[b % `BB_BANK_COUNT][(start + i) % `BB_BANK_DEPTH]);
        end
    endtask

    always @(negedge aclk) begin : out_monitor
        logic [`BB_DATA_WIDTH-1:0] exp_word;
        if (aresetn && out_beat.valid) begin
            beats_seen = beats_seen + 1;
            assert (exp_q.size() > 0)
                else fail_now("out_beat presented with no read word pending");
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                check_eq("out_beat.data", exp_word, out_beat.data);
            end
        end
    end

    // ==============================
    // Protocol checks
    // ==============================
    assert property (@(posedge aclk) disable iff (!aresetn)
                     axil_rsp.awready == axil_rsp.wready)
        else fail_now("awready and wready differ");

    // Address and data offered together while no response is pending
    assert property (@(posedge aclk) disable iff (!aresetn)
                     axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid
                     |-> axil_rsp.awready && axil_rsp.wready)
        else fail_now("write address and data offered but not accepted");

    assert property (@(posedge aclk) disable iff (!aresetn)
                     axil_rsp.awready |=> axil_rsp.bvalid)
        else fail_now("bvalid did not follow an accepted write");

    assert property (@(posedge aclk) disable iff (!aresetn) out_beat.valid |-> reads_open)
        else fail_now("out_beat presented outside a read batch");

    initial begin
        aresetn    = 1'b0;
        axil_req   = '0;
        in_beat    = '0;
        lcg_state  = 32'hb40e_9cc2;
        beats_seen = 0;
        reads_open = 1'b0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;

        // Idle outputs after reset
        @(negedge aclk);
        check_eq("awready/wready/bvalid/rvalid/out_beat.valid", 32'h0,
                 {27'd0, axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                  axil_rsp.rvalid, out_beat.valid});
        axil_read(`BB_REG_STATUS, rd_word);
        check_eq("STATUS", 32'h0, rd_word);

        // Register readback and an OP_NONE command that launches nothing
        program_side(1'b0, 0, 2, 58, 12);
        program_side(1'b1, 0, 2, 58, 12);
        axil_read(`BB_REG_WR_BANKS, rd_word);
        check_eq("WR_BANKS", 32'h0000_0200, rd_word);
        axil_read(`BB_REG_WR_SPAN, rd_word);
        check_eq("WR_SPAN", 32'h000c_003a, rd_word);
        axil_read(`BB_REG_RD_BANKS, rd_word);
        check_eq("RD_BANKS", 32'h0000_0200, rd_word);
        axil_read(`BB_REG_RD_SPAN, rd_word);
        check_eq("RD_SPAN", 32'h000c_003a, rd_word);
        axil_write(`BB_REG_CMD, 32'(OP_NONE));
        axil_read(`BB_REG_STATUS, rd_word);
        check_eq("STATUS", 32'h0, rd_word);

        // Write batch over banks 0 to 2 with a window wrapping past the top
        axil_write(`BB_REG_CMD, 32'(OP_WRITE));
        axil_read(`BB_REG_STATUS, rd_word);
        check_eq("STATUS", 32'h1, rd_word);
        feed_banks(0, 2, 58, 12);
        wait_idle(rd_word);
        check_eq("STATUS", 32'h2, rd_word);

        // Read batch over the same banks
        queue_reads(0, 2, 58, 12);
        beats_before = beats_seen;
        reads_open   = 1'b1;
        axil_write(`BB_REG_CMD, 32'(OP_READ));
        wait_idle(rd_word);
        check_eq("STATUS", 32'h4, rd_word);
        check_eq("out_beat count", 32'd36, 32'(beats_seen - beats_before));
        check_eq("pending read words", 32'd0, 32'(exp_q.size()));
        reads_open = 1'b0;

        // ==============================
        // Duplex with a CMD write while busy
        // ==============================
        program_side(1'b0, 3, 3, 5, 20);
        program_side(1'b1, 0, 1, 58, 12);
        queue_reads(0, 1, 58, 12);
        beats_before = beats_seen;
        reads_open   = 1'b1;
        axil_write(`BB_REG_CMD, 32'(OP_DUPLEX));
        axil_write(`BB_REG_CMD, 32'(OP_WRITE));   // Dropped while the engine is busy
        axil_read(`BB_REG_CMD, rd_word);
        check_eq("CMD", 32'(OP_DUPLEX), rd_word);
        axil_read(`BB_REG_STATUS, rd_word);
        check_eq("STATUS", 32'h1, rd_word);
        feed_banks(3, 3, 5, 20);
        wait_idle(rd_word);
        check_eq("STATUS", 32'h6, rd_word);
        check_eq("out_beat count", 32'd24, 32'(beats_seen - beats_before));
        check_eq("pending read words", 32'd0, 32'(exp_q.size()));

        // Bank 3 contents from the duplex write side
        program_side(1'b1, 3, 3, 5, 20);
        queue_reads(3, 3, 5, 20);
        beats_before = beats_seen;
        axil_write(`BB_REG_CMD, 32'(OP_READ));
        wait_idle(rd_word);
        check_eq("STATUS", 32'h4, rd_word);
        check_eq("out_beat count", 32'd20, 32'(beats_seen - beats_before));
        check_eq("pending read words", 32'd0, 32'(exp_q.size()));
        reads_open = 1'b0;

        // Zero count read gives no beats
        program_side(1'b1, 0, 2, 0, 0);
        beats_before = beats_seen;
        axil_write(`BB_REG_CMD, 32'(OP_READ));
        wait_idle(rd_word);
        check_eq("STATUS", 32'h4, rd_word);
        check_eq("out_beat count", 32'd0, 32'(beats_seen - beats_before));

        $display("** PASS **");
        $finish;
    end

endmodule

//--- src/axil_cmd_regs.sv
`timescale 1ns/1ps
`include "bram_batch_cfg.svh"

module axil_cmd_regs (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  bram_batch_pkg::axil_req_t  axil_req,
    output bram_batch_pkg::axil_rsp_t  axil_rsp,
    output logic                       launch,
    output bram_batch_pkg::batch_cmd_t cmd,
    input  logic                       batch_done,
    input  logic                       wr_done_set,
    input  logic                       rd_done_set
);
    import bram_batch_pkg::*;

    logic        aw_hs;
    logic        ar_hs;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_mux;
    logic [15:0] wr_banks_q;
    logic [15:0] rd_banks_q;
    logic [31:0] wr_span_q;
    logic [31:0] rd_span_q;
    batch_op_e   op_q;
    batch_op_e   wr_op;
    logic        launch_q;
    logic        busy_q;
    logic        wr_done_q;
    logic        rd_done_q;

    function automatic logic [31:0] merge_strb(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    // ==============================
    // Write channel
    // ==============================
    assign aw_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign wr_op = batch_op_e'(axil_req.wstrb[0] ? axil_req.wdata[1:0] : 2'b00);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bvalid_q   <= 1'b0;
            wr_banks_q <= '0;
            rd_banks_q <= '0;
            wr_span_q  <= '0;
            rd_span_q  <= '0;
            op_q       <= OP_NONE;
            launch_q   <= 1'b0;
            busy_q     <= 1'b0;
            wr_done_q  <= 1'b0;
            rd_done_q  <= 1'b0;
        end else begin
            launch_q <= 1'b0;
            if (aw_hs)
                bvalid_q <= 1'b1;
            else if (axil_req.bready)
                bvalid_q <= 1'b0;

            if (batch_done) begin
                busy_q <= 1'b0;
                if (wr_done_set) wr_done_q <= 1'b1;
                if (rd_done_set) rd_done_q <= 1'b1;
            end

            if (aw_hs) begin
                case (axil_req.awaddr)
                    `BB_REG_CMD: begin
                        if (!busy_q && wr_op != OP_NONE) begin
                            op_q      <= wr_op;
                            launch_q  <= 1'b1;
                            busy_q    <= 1'b1;
                            wr_done_q <= 1'b0;
                            rd_done_q <= 1'b0;
                        end
                    end
                    `BB_REG_WR_BANKS: begin
                        if (axil_req.wstrb[0]) wr_banks_q[7:0]  <= axil_req.wdata[7:0];
                        if (axil_req.wstrb[1]) wr_banks_q[15:8] <= axil_req.wdata[15:8];
                    end
                    `BB_REG_RD_BANKS: begin
                        if (axil_req.wstrb[0]) rd_banks_q[7:0]  <= axil_req.wdata[7:0];
                        if (axil_req.wstrb[1]) rd_banks_q[15:8] <= axil_req.wdata[15:8];
                    end
                    `BB_REG_WR_SPAN:
                        wr_span_q <= merge_strb(wr_span_q, axil_req.wdata, axil_req.wstrb);
                    `BB_REG_RD_SPAN:
                        rd_span_q <= merge_strb(rd_span_q, axil_req.wdata, axil_req.wstrb);
                    default: ;   // STATUS is read-only
                endcase
            end
        end
    end

    // ==============================
    // Read channel
    // ==============================
    assign ar_hs = axil_req.arvalid && !rvalid_q;

    always_comb begin
        case (axil_req.araddr)
            `BB_REG_CMD:      rd_mux = {30'd0, op_q};
            `BB_REG_WR_BANKS: rd_mux = {16'd0, wr_banks_q};
            `BB_REG_WR_SPAN:  rd_mux = wr_span_q;
            `BB_REG_RD_BANKS: rd_mux = {16'd0, rd_banks_q};
            `BB_REG_RD_SPAN:  rd_mux = rd_span_q;
            `BB_REG_STATUS:   rd_mux = {29'd0, rd_done_q, wr_done_q, busy_q};
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            rvalid_q <= 1'b0;
        else if (ar_hs)
            rvalid_q <= 1'b1;
        else if (axil_req.rready)
            rvalid_q <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (ar_hs)
            rdata_q <= rd_mux;
    end

    assign axil_rsp.awready = aw_hs;
    assign axil_rsp.wready  = aw_hs;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = 2'b00;
    assign axil_rsp.arready = !rvalid_q;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = 2'b00;

    assign launch            = launch_q;
    assign cmd.op            = op_q;
    assign cmd.wr_first      = wr_banks_q[7:0];
    assign cmd.wr_last       = wr_banks_q[15:8];
    assign cmd.wr_addr_start = wr_span_q[15:0];
    assign cmd.wr_addr_count = wr_span_q[31:16];
    assign cmd.rd_first      = rd_banks_q[7:0];
    assign cmd.rd_last       = rd_banks_q[15:8];
    assign cmd.rd_addr_start = rd_span_q[15:0];
    assign cmd.rd_addr_count = rd_span_q[31:16];

endmodule

//--- src/bank_array.sv
`timescale 1ns/1ps
`include "bram_batch_cfg.svh"

module bank_array (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  bram_batch_pkg::span_pos_t    wr_pos,
    input  bram_batch_pkg::span_pos_t    rd_pos,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  logic [7:0]                   wr_bank,
    input  logic [7:0]                   rd_bank,
    input  bram_batch_pkg::stream_beat_t in_beat,
    output bram_batch_pkg::stream_beat_t out_beat
);

    localparam int BANK_BITS = $clog2(`BB_BANK_COUNT);
    localparam int ADDR_BITS = $clog2(`BB_BANK_DEPTH);

    logic                      wr_hit;
    logic                      rd_hit;
    logic [BANK_BITS-1:0]      wr_sel;
    logic [BANK_BITS-1:0]      rd_sel;
    logic [BANK_BITS-1:0]      rd_sel_q;
    logic                      rd_valid_q;
    logic [`BB_DATA_WIDTH-1:0] bank_q [`BB_BANK_COUNT];

    assign wr_hit = wr_en && wr_pos.active;
    assign rd_hit = rd_en && rd_pos.active;
    assign wr_sel = wr_bank[BANK_BITS-1:0];   // Bank index modulo count
    assign rd_sel = rd_bank[BANK_BITS-1:0];

    for (genvar b = 0; b < `BB_BANK_COUNT; b++) begin : g_bank
        logic [`BB_DATA_WIDTH-1:0] mem [`BB_BANK_DEPTH];
        logic [`BB_DATA_WIDTH-1:0] q;

        always_ff @(posedge aclk) begin
            if (wr_hit && wr_sel == BANK_BITS'(b))
                mem[wr_pos.addr[ADDR_BITS-1:0]] <= in_beat.data;
            if (rd_hit && rd_sel == BANK_BITS'(b))
                q <= mem[rd_pos.addr[ADDR_BITS-1:0]];
        end

        assign bank_q[b] = q;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            rd_valid_q <= 1'b0;
        else
            rd_valid_q <= rd_hit;
    end

    always_ff @(posedge aclk) begin
        if (rd_hit)
            rd_sel_q <= rd_sel;
    end

    assign out_beat.valid = rd_valid_q;
    assign out_beat.data  = bank_q[rd_sel_q];   // Read mux after the bank registers

endmodule

//--- src/batch_sequencer.sv
`timescale 1ns/1ps

module batch_sequencer (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       launch,
    input  bram_batch_pkg::batch_cmd_t cmd,
    output bram_batch_pkg::span_ctl_t  wr_ctl,
    output bram_batch_pkg::span_ctl_t  rd_ctl,
    input  bram_batch_pkg::span_pos_t  wr_pos,
    input  bram_batch_pkg::span_pos_t  rd_pos,
    input  logic                       in_valid,
    output logic [7:0]                 wr_bank,
    output logic [7:0]                 rd_bank,
    output logic                       batch_done,
    output logic                       wr_done_set,
    output logic                       rd_done_set
);
    import bram_batch_pkg::*;

    seq_state_e  state_q;
    seq_state_e  state_d;
    batch_op_e   op_q;
    logic [7:0]  wr_bank_q;
    logic [7:0]  rd_bank_q;
    logic [7:0]  wr_last_q;
    logic [7:0]  rd_last_q;
    logic [15:0] wr_start_q;
    logic [15:0] wr_count_q;
    logic [15:0] rd_start_q;
    logic [15:0] rd_count_q;
    logic        wr_fin_q;
    logic        rd_fin_q;
    logic        idle_launch;
    logic        in_run;
    logic        wr_at_last;
    logic        rd_at_last;
    logic        wr_step;
    logic        rd_step;
    logic        wr_end;
    logic        rd_end;

    assign idle_launch = (state_q == S_IDLE) && launch;
    assign in_run      = state_q inside {S_WR_RUN, S_RD_RUN, S_DX_RUN};

    // first > last also lands here on the first bank
    assign wr_at_last = wr_bank_q >= wr_last_q;
    assign rd_at_last = rd_bank_q >= rd_last_q;

    // A side steps when its counter drains its current bank
    assign wr_step = in_run && !wr_fin_q && wr_pos.done;
    assign rd_step = in_run && !rd_fin_q && rd_pos.done;
    assign wr_end  = wr_fin_q || (wr_step && wr_at_last);
    assign rd_end  = rd_fin_q || (rd_step && rd_at_last);

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (launch) begin
                    case (cmd.op)
                        OP_WRITE:  state_d = S_WR_SETUP;
                        OP_READ:   state_d = S_RD_SETUP;
                        OP_DUPLEX: state_d = S_DX_SETUP;
                        default:   state_d = S_IDLE;
                    endcase
                end
            end
            S_WR_SETUP: state_d = S_WR_RUN;
            S_RD_SETUP: state_d = S_RD_RUN;
            S_DX_SETUP: state_d = S_DX_RUN;
            S_WR_RUN, S_RD_RUN, S_DX_RUN: begin
                if (wr_end && rd_end)
                    state_d = S_DONE;
            end
            S_DONE:  state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q   <= S_IDLE;
            wr_bank_q <= '0;
            rd_bank_q <= '0;
            wr_fin_q  <= 1'b1;
            rd_fin_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            if (idle_launch) begin
                wr_bank_q <= cmd.wr_first;
                rd_bank_q <= cmd.rd_first;
                wr_fin_q  <= !(cmd.op inside {OP_WRITE, OP_DUPLEX});   // Unused side starts finished
                rd_fin_q  <= !(cmd.op inside {OP_READ, OP_DUPLEX});
            end
            if (wr_step) begin
                if (wr_at_last)
                    wr_fin_q <= 1'b1;
                else
                    wr_bank_q <= wr_bank_q + 8'd1;
            end
            if (rd_step) begin
                if (rd_at_last)
                    rd_fin_q <= 1'b1;
                else
                    rd_bank_q <= rd_bank_q + 8'd1;
            end
        end
    end

    // Command copy for the batch
    always_ff @(posedge aclk) begin
        if (idle_launch) begin
            op_q       <= cmd.op;
            wr_last_q  <= cmd.wr_last;
            rd_last_q  <= cmd.rd_last;
            wr_start_q <= cmd.wr_addr_start;
            wr_count_q <= cmd.wr_addr_count;
            rd_start_q <= cmd.rd_addr_start;
            rd_count_q <= cmd.rd_addr_count;
        end
    end

    // ==============================
    // Counter control
    // ==============================
    assign wr_ctl.start       = (state_q inside {S_WR_SETUP, S_DX_SETUP}) ||
                                (wr_step && !wr_at_last);
    assign wr_ctl.enable      = in_run && !wr_fin_q && in_valid;   // Input gaps stall
    assign wr_ctl.start_addr  = wr_start_q;
    assign wr_ctl.count_limit = wr_count_q;

    assign rd_ctl.start       = (state_q inside {S_RD_SETUP, S_DX_SETUP}) ||
                                (rd_step && !rd_at_last);
    assign rd_ctl.enable      = in_run && !rd_fin_q;
    assign rd_ctl.start_addr  = rd_start_q;
    assign rd_ctl.count_limit = rd_count_q;

    assign wr_bank = wr_bank_q;
    assign rd_bank = rd_bank_q;

    assign batch_done  = state_q == S_DONE;
    assign wr_done_set = (state_q == S_DONE) && (op_q inside {OP_WRITE, OP_DUPLEX});
    assign rd_done_set = (state_q == S_DONE) && (op_q inside {OP_READ, OP_DUPLEX});

endmodule

//--- src/bram_batch_pkg.sv
`include "bram_batch_cfg.svh"

package bram_batch_pkg;

    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_WRITE  = 2'd1,
        OP_READ   = 2'd2,
        OP_DUPLEX = 2'd3
    } batch_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_SETUP,
        S_WR_RUN,
        S_RD_SETUP,
        S_RD_RUN,
        S_DX_SETUP,
        S_DX_RUN,
        S_DONE
    } seq_state_e;

    // Full batch command as launched
    typedef struct packed {
        batch_op_e   op;
        logic [7:0]  wr_first;
        logic [7:0]  wr_last;
        logic [15:0] wr_addr_start;
        logic [15:0] wr_addr_count;
        logic [7:0]  rd_first;
        logic [7:0]  rd_last;
        logic [15:0] rd_addr_start;
        logic [15:0] rd_addr_count;
    } batch_cmd_t;

    typedef struct packed {
        logic        start;        // Load address and count
        logic        enable;
        logic [15:0] start_addr;
        logic [15:0] count_limit;
    } span_ctl_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        active;       // Words remain in this pass
        logic        done;
    } span_pos_t;

    typedef struct packed {
        logic                      valid;
        logic [`BB_DATA_WIDTH-1:0] data;
    } stream_beat_t;

    // ==============================
    // AXI4-Lite channels by direction
    // ==============================
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

//--- src/bram_batch_top.sv
`timescale 1ns/1ps

module bram_batch_top (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  bram_batch_pkg::axil_req_t    axil_req,
    output bram_batch_pkg::axil_rsp_t    axil_rsp,
    input  bram_batch_pkg::stream_beat_t in_beat,
    output bram_batch_pkg::stream_beat_t out_beat
);
    import bram_batch_pkg::*;

    logic       launch;
    batch_cmd_t cmd;
    logic       batch_done;
    logic       wr_done_set;
    logic       rd_done_set;
    span_ctl_t  wr_ctl;
    span_ctl_t  rd_ctl;
    span_pos_t  wr_pos;
    span_pos_t  rd_pos;
    logic [7:0] wr_bank;
    logic [7:0] rd_bank;

    axil_cmd_regs u_regs (
        .aclk, .aresetn, .axil_req, .axil_rsp,
        .launch, .cmd, .batch_done, .wr_done_set, .rd_done_set
    );

    batch_sequencer u_seq (
        .aclk, .aresetn, .launch, .cmd,
        .wr_ctl, .rd_ctl, .wr_pos, .rd_pos,
        .in_valid (in_beat.valid),
        .wr_bank, .rd_bank, .batch_done, .wr_done_set, .rd_done_set
    );

    span_counter u_wr_span (.aclk, .aresetn, .ctl(wr_ctl), .pos(wr_pos));
    span_counter u_rd_span (.aclk, .aresetn, .ctl(rd_ctl), .pos(rd_pos));

    bank_array u_banks (
        .aclk, .aresetn, .wr_pos, .rd_pos,
        .wr_en (wr_ctl.enable),
        .rd_en (rd_ctl.enable),
        .wr_bank, .rd_bank, .in_beat, .out_beat
    );

endmodule

//--- src/span_counter.sv
`timescale 1ns/1ps

module span_counter (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  bram_batch_pkg::span_ctl_t ctl,
    output bram_batch_pkg::span_pos_t pos
);

    logic [15:0] addr_q;
    logic [15:0] remain_q;
    logic        step;

    assign step = ctl.enable && (remain_q != 16'd0);

    always_ff @(posedge aclk) begin
        if (!aresetn)
            remain_q <= '0;
        else if (ctl.start)
            remain_q <= ctl.count_limit;
        else if (step)
            remain_q <= remain_q - 16'd1;
    end

    // Address wraps in the bank array
    always_ff @(posedge aclk) begin
        if (ctl.start)
            addr_q <= ctl.start_addr;
        else if (step)
            addr_q <= addr_q + 16'd1;
    end

    assign pos.addr   = addr_q;
    assign pos.active = remain_q != 16'd0;
    assign pos.done   = remain_q == 16'd0;   // Zero count finishes at once

endmodule
